// File: verilog/umode_macros.svh
// Constants for the user-mode compliance monitor.
// Field positions in mstatus, misa and dcsr, fixed instruction
// encodings, trap causes and CSR addresses. Include where needed.

`ifndef UMODE_MACROS_SVH
`define UMODE_MACROS_SVH

// misa extension bits
`define UMODE_MISA_U_POS 20
`define UMODE_MISA_S_POS 18
`define UMODE_MISA_N_POS 13

// mstatus fields
`define UMODE_MPP_POS  11
`define UMODE_MPP_LEN  2
`define UMODE_SPP_POS  8
`define UMODE_MPRV_POS 17
`define UMODE_TW_POS   21
`define UMODE_XS_POS   15
`define UMODE_XS_LEN   2
`define UMODE_FS_POS   13
`define UMODE_FS_LEN   2
`define UMODE_SD_POS   31

// dcsr fields
`define UMODE_PRV_POS    0
`define UMODE_PRV_LEN    2
`define UMODE_MPRVEN_POS 4

// Fixed encodings in the SYSTEM space
`define UMODE_OPCODE_SYSTEM 7'b1110011
`define UMODE_MRET_IDATA    32'h3020_0073
`define UMODE_WFI_IDATA     32'h1050_0073
`define UMODE_URET_IDATA    32'h0020_0073

// Custom SYSTEM encodings compared under mask
`define UMODE_CUSTOM0_IDATA 32'h8C00_0073
`define UMODE_CUSTOM0_IMASK 32'hFC00_707F
`define UMODE_CUSTOM1_IDATA 32'hCC00_0073
`define UMODE_CUSTOM1_IMASK 32'hFC00_707F

// Trap causes as reported on the trace
`define UMODE_EXC_INSTR_FAULT     6'h01
`define UMODE_EXC_ILLEGAL_INSN    6'h02
`define UMODE_EXC_INSTR_BUS_FAULT 6'h18
`define UMODE_DBG_CAUSE_TRIGGER   3'h2

// N extension CSRs
`define UMODE_CSR_USTATUS  12'h000
`define UMODE_CSR_UIE      12'h004
`define UMODE_CSR_UTVEC    12'h005
`define UMODE_CSR_USCRATCH 12'h040
`define UMODE_CSR_UEPC     12'h041
`define UMODE_CSR_UCAUSE   12'h042
`define UMODE_CSR_UTVAL    12'h043
`define UMODE_CSR_UIP      12'h044

// Delegation CSRs are absent without S mode
`define UMODE_CSR_MEDELEG 12'h302
`define UMODE_CSR_MIDELEG 12'h303

`endif

// File: verilog/umode_pkg.sv
// Shared types for the user-mode compliance monitor.
// Holds the privilege mode encoding, the decoded class of a retired
// instruction and the layout of the violation flag vector.

package umode_pkg;

  // Only U and M exist on this core; 1 and 2 are unsupported encodings
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_mode_e;

  // Kind flags are raw decode results that still need the valid qualifier
  typedef struct packed {
    logic valid;       // Retired and not revoked by an instruction fault
    logic mret;
    logic wfi;
    logic uret;
    logic custom;
    logic csr;         // Any Zicsr instruction
    logic ncsr;        // CSR of the N extension
    logic deleg;       // medeleg or mideleg
    logic hipriv;      // CSR address privilege bits above U
    logic revoked;
    logic triggered;
    logic illegal;
  } insn_class_t;

  // Violation bits listed from the MSB down
  // Field slice 19..11, rule slice 10..4, transition slice 3..0
  typedef struct packed {
    logic misa_bits;
    logic mode_unsupported;
    logic initial_mode;
    logic mpp_illegal;
    logic spp_nonzero;
    logic ext_nonzero;
    logic mcounteren_nonzero;
    logic prv_unsupported;
    logic mprven_set;
    logic mret_mpp;
    logic wfi_legality;
    logic custom_legal;
    logic uret_legal;
    logic mret_umode;
    logic csr_hipriv;
    logic csr_absent;      // N extension or delegation CSR accepted
    logic trap_mode;
    logic dbg_mode;
    logic dbg_prv;         // Wrong PRV on debug entry or exit
    logic mret_target;
  } umode_err_t;

endpackage

// File: verilog/insn_classifier.sv
// Decodes one retirement record into an instruction class.
// Purely combinational; the result feeds the rule and transition
// checkers in the same cycle as the record.

`timescale 1ns/1ps
`include "umode_macros.svh"

module insn_classifier (
  input  logic                   rvfi_valid,
  input  logic [31:0]            rvfi_insn,
  input  logic                   trap_valid,
  input  logic                   trap_exception,
  input  logic                   trap_debug,
  input  logic [5:0]             trap_exception_cause,
  input  logic [2:0]             trap_debug_cause,
  output umode_pkg::insn_class_t insn_class
);

  logic [11:0] csr_addr;
  logic        is_system;
  logic        is_csr;
  logic        revoked;

  assign csr_addr  = rvfi_insn[31:20];
  assign is_system = (rvfi_insn[6:0] == `UMODE_OPCODE_SYSTEM);
  // funct3 of 0 and 4 are not Zicsr
  assign is_csr    = is_system && (rvfi_insn[14:12] inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});

  // Fetch faults mean the instruction never really executed
  assign revoked = trap_valid && trap_exception &&
                   (trap_exception_cause inside {`UMODE_EXC_INSTR_FAULT,
                                                 `UMODE_EXC_INSTR_BUS_FAULT});

  always_comb begin
    insn_class.valid     = rvfi_valid && !revoked;
    insn_class.mret      = (rvfi_insn == `UMODE_MRET_IDATA);
    insn_class.wfi       = (rvfi_insn == `UMODE_WFI_IDATA);
    insn_class.uret      = (rvfi_insn == `UMODE_URET_IDATA);
    insn_class.custom    = ((rvfi_insn & `UMODE_CUSTOM0_IMASK) == `UMODE_CUSTOM0_IDATA) ||
                           ((rvfi_insn & `UMODE_CUSTOM1_IMASK) == `UMODE_CUSTOM1_IDATA);
    insn_class.csr       = is_csr;
    insn_class.ncsr      = is_csr && (csr_addr inside {`UMODE_CSR_USTATUS, `UMODE_CSR_UIE,
                                                       `UMODE_CSR_UTVEC, `UMODE_CSR_USCRATCH,
                                                       `UMODE_CSR_UEPC, `UMODE_CSR_UCAUSE,
                                                       `UMODE_CSR_UTVAL, `UMODE_CSR_UIP});
    insn_class.deleg     = is_csr && (csr_addr inside {`UMODE_CSR_MEDELEG,
                                                       `UMODE_CSR_MIDELEG});
    // Address bits 29:28 give the lowest privilege allowed to access
    insn_class.hipriv    = is_csr && (rvfi_insn[29:28] != umode_pkg::PRIV_U);
    insn_class.revoked   = revoked;
    insn_class.triggered = trap_valid && trap_debug &&
                           (trap_debug_cause == `UMODE_DBG_CAUSE_TRIGGER);
    insn_class.illegal   = trap_valid && trap_exception &&
                           (trap_exception_cause == `UMODE_EXC_ILLEGAL_INSN);
  end

endmodule

// File: verilog/csr_field_checker.sv
// Checks the CSR fields that must hold fixed or restricted values
// on a core with only M and U modes. Every retirement is checked on
// its own, so the logic is combinational.

`timescale 1ns/1ps
`include "umode_macros.svh"

module csr_field_checker (
  input  logic                  rvfi_valid,
  input  umode_pkg::priv_mode_e rvfi_mode,
  input  logic [63:0]           rvfi_order,
  input  logic [31:0]           csr_misa_rdata,
  input  logic [31:0]           csr_mstatus_rdata,
  input  logic [31:0]           csr_mcounteren_rdata,
  input  logic [31:0]           csr_dcsr_rdata,
  output logic [8:0]            field_err
);

  logic [1:0] mpp;
  logic [1:0] prv;
  logic       misa_ok;
  logic       mode_ok;
  logic       ext_zero;

  assign mpp = csr_mstatus_rdata[`UMODE_MPP_POS +: `UMODE_MPP_LEN];
  assign prv = csr_dcsr_rdata[`UMODE_PRV_POS +: `UMODE_PRV_LEN];

  // U present, S and N absent
  assign misa_ok = csr_misa_rdata[`UMODE_MISA_U_POS] &&
                   !csr_misa_rdata[`UMODE_MISA_S_POS] &&
                   !csr_misa_rdata[`UMODE_MISA_N_POS];

  assign mode_ok = (rvfi_mode == umode_pkg::PRIV_U) || (rvfi_mode == umode_pkg::PRIV_M);

  // No F, no custom extension state, hence no dirty summary
  assign ext_zero = (csr_mstatus_rdata[`UMODE_XS_POS +: `UMODE_XS_LEN] == 2'b00) &&
                    (csr_mstatus_rdata[`UMODE_FS_POS +: `UMODE_FS_LEN] == 2'b00) &&
                    !csr_mstatus_rdata[`UMODE_SD_POS];

  always_comb begin
    field_err = '0;
    if (rvfi_valid) begin
      field_err[8] = !misa_ok;
      field_err[7] = !mode_ok;
      // Core comes out of reset in M
      field_err[6] = (rvfi_order inside {64'd0, 64'd1}) && (rvfi_mode != umode_pkg::PRIV_M);
      field_err[5] = !(mpp inside {2'b00, 2'b11});
      field_err[4] = csr_mstatus_rdata[`UMODE_SPP_POS];
      field_err[3] = !ext_zero;
      field_err[2] = (csr_mcounteren_rdata != 32'd0);
      field_err[1] = !(prv inside {2'b00, 2'b11});
      field_err[0] = csr_dcsr_rdata[`UMODE_MPRVEN_POS];
    end
  end

endmodule

// File: verilog/privilege_rule_checker.sv
// Legality checks on a single retired instruction.
// Looks at the decoded class together with the mode and mstatus to
// find instructions that should have raised an illegal instruction
// exception in U mode, and MRETs that leave MPP wrong.

`timescale 1ns/1ps
`include "umode_macros.svh"

module privilege_rule_checker (
  input  umode_pkg::insn_class_t insn_class,
  input  umode_pkg::priv_mode_e  rvfi_mode,
  input  logic [31:0]            csr_mstatus_rdata,
  input  logic [31:0]            csr_mstatus_wdata,
  input  logic [31:0]            csr_mstatus_wmask,
  output logic [6:0]             rule_err
);

  logic [31:0] mstatus_post;
  logic        in_umode;
  logic        tw;
  logic        ok_illegal;

  // Written bits replace the old value, the rest carry over
  assign mstatus_post = (csr_mstatus_wdata & csr_mstatus_wmask) |
                        (csr_mstatus_rdata & ~csr_mstatus_wmask);

  assign in_umode   = (rvfi_mode == umode_pkg::PRIV_U);
  assign tw         = csr_mstatus_rdata[`UMODE_TW_POS];
  assign ok_illegal = insn_class.illegal;

  always_comb begin
    rule_err = '0;
    if (insn_class.valid) begin
      // MRET always drops MPP to the lowest mode
      rule_err[6] = insn_class.mret &&
                    (mstatus_post[`UMODE_MPP_POS +: `UMODE_MPP_LEN] != umode_pkg::PRIV_U);
      // TW set makes WFI trap in U, clear makes it run normally
      rule_err[5] = insn_class.wfi && in_umode && (tw ? !ok_illegal : ok_illegal);
      rule_err[4] = insn_class.custom && !ok_illegal;
      rule_err[3] = insn_class.uret && !ok_illegal;
      // A trigger may fire first, but never both outcomes at once
      rule_err[2] = insn_class.mret && in_umode &&
                    !(ok_illegal ^ insn_class.triggered);
      rule_err[1] = insn_class.hipriv && in_umode && !ok_illegal;
      rule_err[0] = (insn_class.ncsr || insn_class.deleg) && !ok_illegal;
    end
  end

endmodule

// File: verilog/mode_transition_checker.sv
// Rules spanning two retirements.
// Keeps a small history of the previous retirement and checks the
// current record against it: mode after a trap, debug entry and exit,
// and the target mode of an MRET. The debug-implies-M check needs no
// history and lives here with the other debug rules.

`timescale 1ns/1ps
`include "umode_macros.svh"

module mode_transition_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rvfi_valid,
  input  umode_pkg::priv_mode_e  rvfi_mode,
  input  logic                   rvfi_dbg_mode,
  input  umode_pkg::insn_class_t insn_class,
  input  logic                   intr_valid,
  input  logic                   intr_interrupt,
  input  logic [31:0]            csr_mcause_rdata,
  input  logic [31:0]            csr_mstatus_rdata,
  input  logic [31:0]            csr_dcsr_rdata,
  output logic [3:0]             trans_err
);

  logic                  hist_valid;
  logic                  hist_trap;
  logic                  hist_mret;
  umode_pkg::priv_mode_e hist_mode;
  logic                  hist_dbg;
  logic [1:0]            hist_prv;
  logic [1:0]            hist_mpp;
  logic                  trapped;
  logic                  mret_from_m;
  logic                  intr_taken;
  logic [1:0]            cur_prv;

  // Traps as seen through the decoded class
  assign trapped     = insn_class.revoked || insn_class.triggered || insn_class.illegal;
  assign mret_from_m = insn_class.valid && insn_class.mret &&
                       (rvfi_mode == umode_pkg::PRIV_M) && !rvfi_dbg_mode;
  assign intr_taken  = intr_valid && intr_interrupt && csr_mcause_rdata[31];
  assign cur_prv     = csr_dcsr_rdata[`UMODE_PRV_POS +: `UMODE_PRV_LEN];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hist_valid <= 1'b0;
      hist_trap  <= 1'b0;
      hist_mret  <= 1'b0;
    end else if (rvfi_valid) begin
      hist_valid <= 1'b1;
      hist_trap  <= trapped;
      hist_mret  <= mret_from_m;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid) begin
      hist_mode <= rvfi_mode;
      hist_dbg  <= rvfi_dbg_mode;
      hist_prv  <= cur_prv;
      hist_mpp  <= csr_mstatus_rdata[`UMODE_MPP_POS +: `UMODE_MPP_LEN];
    end
  end

  always_comb begin
    trans_err = '0;
    if (rvfi_valid) begin
      trans_err[2] = rvfi_dbg_mode && (rvfi_mode != umode_pkg::PRIV_M);
      if (hist_valid) begin
        trans_err[3] = hist_trap && (rvfi_mode != umode_pkg::PRIV_M);
        // Exit resumes in dcsr.PRV, entry records the old mode there
        trans_err[1] = (hist_dbg && !rvfi_dbg_mode && (rvfi_mode != hist_prv)) ||
                       (!hist_dbg && rvfi_dbg_mode && (cur_prv != hist_mode));
        trans_err[0] = hist_mret && !intr_taken && !rvfi_dbg_mode &&
                       (rvfi_mode != hist_mpp);
      end
    end
  end

endmodule

// File: verilog/umode_monitor.sv
// Top of the user-mode compliance monitor.
// Attach to the retirement trace of an M/U core. Each retirement's
// violations appear on err_flags one cycle later, and retired_mode
// follows the mode of the last retired instruction.

`timescale 1ns/1ps

module umode_monitor (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rvfi_valid,
  input  umode_pkg::priv_mode_e rvfi_mode,
  input  logic [63:0]           rvfi_order,
  input  logic [31:0]           rvfi_insn,
  input  logic                  trap_valid,
  input  logic                  trap_exception,
  input  logic                  trap_debug,
  input  logic [5:0]            trap_exception_cause,
  input  logic [2:0]            trap_debug_cause,
  input  logic                  intr_valid,
  input  logic                  intr_interrupt,
  input  logic                  rvfi_dbg_mode,
  input  logic [31:0]           csr_misa_rdata,
  input  logic [31:0]           csr_mstatus_rdata,
  input  logic [31:0]           csr_mcounteren_rdata,
  input  logic [31:0]           csr_dcsr_rdata,
  input  logic [31:0]           csr_mcause_rdata,
  input  logic [31:0]           csr_mstatus_wdata,
  input  logic [31:0]           csr_mstatus_wmask,
  output umode_pkg::umode_err_t err_flags,
  output umode_pkg::priv_mode_e retired_mode
);

  umode_pkg::insn_class_t insn_class;
  umode_pkg::umode_err_t  err_d;
  logic [8:0]             field_err;
  logic [6:0]             rule_err;
  logic [3:0]             trans_err;

  insn_classifier u_classifier (
    .rvfi_valid           (rvfi_valid),
    .rvfi_insn            (rvfi_insn),
    .trap_valid           (trap_valid),
    .trap_exception       (trap_exception),
    .trap_debug           (trap_debug),
    .trap_exception_cause (trap_exception_cause),
    .trap_debug_cause     (trap_debug_cause),
    .insn_class           (insn_class)
  );

  csr_field_checker u_field (
    .rvfi_valid           (rvfi_valid),
    .rvfi_mode            (rvfi_mode),
    .rvfi_order           (rvfi_order),
    .csr_misa_rdata       (csr_misa_rdata),
    .csr_mstatus_rdata    (csr_mstatus_rdata),
    .csr_mcounteren_rdata (csr_mcounteren_rdata),
    .csr_dcsr_rdata       (csr_dcsr_rdata),
    .field_err            (field_err)
  );

  privilege_rule_checker u_rule (
    .insn_class        (insn_class),
    .rvfi_mode         (rvfi_mode),
    .csr_mstatus_rdata (csr_mstatus_rdata),
    .csr_mstatus_wdata (csr_mstatus_wdata),
    .csr_mstatus_wmask (csr_mstatus_wmask),
    .rule_err          (rule_err)
  );

  mode_transition_checker u_trans (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid        (rvfi_valid),
    .rvfi_mode         (rvfi_mode),
    .rvfi_dbg_mode     (rvfi_dbg_mode),
    .insn_class        (insn_class),
    .intr_valid        (intr_valid),
    .intr_interrupt    (intr_interrupt),
    .csr_mcause_rdata  (csr_mcause_rdata),
    .csr_mstatus_rdata (csr_mstatus_rdata),
    .csr_dcsr_rdata    (csr_dcsr_rdata),
    .trans_err         (trans_err)
  );

  // Slice order matches the field order of the flag struct
  assign err_d = umode_pkg::umode_err_t'({field_err, rule_err, trans_err});

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_flags    <= '0;
      retired_mode <= umode_pkg::PRIV_M;
    end else begin
      // Flags are one-cycle levels that are zero when nothing retired
      err_flags <= rvfi_valid ? err_d : '0;
      if (rvfi_valid) begin
        retired_mode <= rvfi_mode;
      end
    end
  end

endmodule

// File: verification/tb_clock_gen.sv
// Free-running clock for the monitor testbench.
// Starts low and toggles every half period, 100 ns per cycle.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter time HALF_PERIOD = 50ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

// File: verification/tb_umode_monitor.sv
// Testbench for the user-mode compliance monitor.
// Reads retirement records and their expected results from the golden
// data file, drives one record per clock and checks each record's
// flags and retired mode one cycle after it was sampled.

`timescale 1ns/1ps

module tb_umode_monitor;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_LINES    = 256;

  logic                  clk;
  logic                  rst_n;
  logic                  rvfi_valid;
  umode_pkg::priv_mode_e rvfi_mode;
  logic [63:0]           rvfi_order;
  logic [31:0]           rvfi_insn;
  logic                  trap_valid;
  logic                  trap_exception;
  logic                  trap_debug;
  logic [5:0]            trap_exception_cause;
  logic [2:0]            trap_debug_cause;
  logic                  intr_valid;
  logic                  intr_interrupt;
  logic                  rvfi_dbg_mode;
  logic [31:0]           csr_misa_rdata;
  logic [31:0]           csr_mstatus_rdata;
  logic [31:0]           csr_mcounteren_rdata;
  logic [31:0]           csr_dcsr_rdata;
  logic [31:0]           csr_mcause_rdata;
  logic [31:0]           csr_mstatus_wdata;
  logic [31:0]           csr_mstatus_wmask;
  umode_pkg::umode_err_t err_flags;
  umode_pkg::priv_mode_e retired_mode;

  int errors;
  int tests;
  int failed_tests;

  tb_clock_gen u_clock (.clk(clk));

  umode_monitor dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .rvfi_valid (rvfi_valid), .rvfi_mode (rvfi_mode),
    .rvfi_order (rvfi_order), .rvfi_insn (rvfi_insn),
    .trap_valid (trap_valid), .trap_exception (trap_exception),
    .trap_debug (trap_debug), .trap_exception_cause (trap_exception_cause),
    .trap_debug_cause (trap_debug_cause),
    .intr_valid (intr_valid), .intr_interrupt (intr_interrupt),
    .rvfi_dbg_mode (rvfi_dbg_mode),
    .csr_misa_rdata (csr_misa_rdata), .csr_mstatus_rdata (csr_mstatus_rdata),
    .csr_mcounteren_rdata (csr_mcounteren_rdata), .csr_dcsr_rdata (csr_dcsr_rdata),
    .csr_mcause_rdata (csr_mcause_rdata),
    .csr_mstatus_wdata (csr_mstatus_wdata), .csr_mstatus_wmask (csr_mstatus_wmask),
    .err_flags (err_flags), .retired_mode (retired_mode)
  );

  task automatic check_flags(input logic [8*16-1:0] name, input umode_pkg::umode_err_t exp,
                             input umode_pkg::umode_err_t act);
    if (act !== exp) begin
      $display("MISMATCH %0s err_flags expected %05h actual %05h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mode(input logic [8*16-1:0] name, input umode_pkg::priv_mode_e exp,
                            input umode_pkg::priv_mode_e act);
    if (act !== exp) begin
      $display("MISMATCH %0s retired_mode expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // Checks both outputs for one test and prints its result line
  task automatic score_record(input logic [8*16-1:0] name, input umode_pkg::umode_err_t exp_err,
                              input umode_pkg::priv_mode_e exp_mode);
    int errors_before;
    errors_before = errors;
    check_flags(name, exp_err, err_flags);
    check_mode(name, exp_mode, retired_mode);
    tests++;
    if (errors == errors_before) begin
      $display("test %0s ok", name);
    end else begin
      failed_tests++;
      $display("test %0s failed", name);
    end
  endtask

  initial begin : main
    logic [8*256-1:0]      line;
    logic [8*16-1:0]       tok;
    logic [8*16-1:0]       name;
    logic [8*16-1:0]       prev_name;
    logic [1:0]            f_mode;
    logic [1:0]            f_rmode;
    logic [2:0]            f_trap;
    logic [1:0]            f_intr;
    logic                  f_valid;
    logic                  f_dbg;
    logic [63:0]           f_order;
    logic [31:0]           f_insn;
    logic [5:0]            f_exc;
    logic [2:0]            f_dbgc;
    logic [31:0]           f_misa;
    logic [31:0]           f_mst;
    logic [31:0]           f_mcnt;
    logic [31:0]           f_dcsr;
    logic [31:0]           f_mcause;
    logic [31:0]           f_wdata;
    logic [31:0]           f_wmask;
    umode_pkg::umode_err_t f_err;
    umode_pkg::umode_err_t prev_err;
    umode_pkg::priv_mode_e prev_mode;
    logic                  have_prev;
    logic                  run_ok;
    int                    fd;
    int                    n;
    int                    lines;
    int                    cycles;

    errors = 0;
    tests = 0;
    failed_tests = 0;
    have_prev = 1'b0;
    run_ok = 1'b1;
    rst_n = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_mode = umode_pkg::PRIV_M;
    rvfi_order = '0;
    rvfi_insn = '0;
    trap_valid = 1'b0;
    trap_exception = 1'b0;
    trap_debug = 1'b0;
    trap_exception_cause = '0;
    trap_debug_cause = '0;
    intr_valid = 1'b0;
    intr_interrupt = 1'b0;
    rvfi_dbg_mode = 1'b0;
    csr_misa_rdata = '0;
    csr_mstatus_rdata = '0;
    csr_mcounteren_rdata = '0;
    csr_dcsr_rdata = '0;
    csr_mcause_rdata = '0;
    csr_mstatus_wdata = '0;
    csr_mstatus_wmask = '0;

    fd = $fopen("verification/umode_golden.dat", "r");
    if (fd == 0) begin
      $display("could not open the golden data file");
      run_ok = 1'b0;
    end else begin
      cycles = 0;
      while (cycles < RESET_CYCLES) begin
        @(posedge clk);
        cycles++;
      end
      rst_n <= 1'b1;
      @(negedge clk);
      score_record("reset", '0, umode_pkg::PRIV_M);

      lines = 0;
      while (!$feof(fd) && lines < MAX_LINES) begin
        lines++;
        line = '0;
        tok = '0;
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%s", tok);
        end
        // Lines starting with a lone hash are column notes
        if (n == 1 && tok != {120'd0, "#"}) begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      name, f_valid, f_mode, f_order, f_insn, f_trap, f_exc, f_dbgc,
                      f_intr, f_dbg, f_misa, f_mst, f_mcnt, f_dcsr, f_mcause,
                      f_wdata, f_wmask, f_err, f_rmode);
          if (n == 19) begin
            @(posedge clk);
            rvfi_valid <= f_valid;
            rvfi_mode <= umode_pkg::priv_mode_e'(f_mode);
            rvfi_order <= f_order;
            rvfi_insn <= f_insn;
            trap_valid <= f_trap[2];
            trap_exception <= f_trap[1];
            trap_debug <= f_trap[0];
            trap_exception_cause <= f_exc;
            trap_debug_cause <= f_dbgc;
            intr_valid <= f_intr[1];
            intr_interrupt <= f_intr[0];
            rvfi_dbg_mode <= f_dbg;
            csr_misa_rdata <= f_misa;
            csr_mstatus_rdata <= f_mst;
            csr_mcounteren_rdata <= f_mcnt;
            csr_dcsr_rdata <= f_dcsr;
            csr_mcause_rdata <= f_mcause;
            csr_mstatus_wdata <= f_wdata;
            csr_mstatus_wmask <= f_wmask;
            // Outputs now show the record driven one edge earlier
            @(negedge clk);
            if (have_prev) begin
              score_record(prev_name, prev_err, prev_mode);
            end
            have_prev = 1'b1;
            prev_name = name;
            prev_err = f_err;
            prev_mode = umode_pkg::priv_mode_e'(f_rmode);
          end else begin
            $display("golden data line %0d has %0d of 19 columns", lines, n);
            errors++;
          end
        end
      end
      if (!$feof(fd)) begin
        $display("golden data file did not end within %0d lines", MAX_LINES);
        run_ok = 1'b0;
      end
      $fclose(fd);

      @(posedge clk);
      rvfi_valid <= 1'b0;
      @(negedge clk);
      if (have_prev) begin
        score_record(prev_name, prev_err, prev_mode);
      end
    end

    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (run_ok && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verification/umode_golden.dat
# name valid mode order insn trap(v,exc,dbg) exc_cause dbg_cause intr(v,int) dbg_mode misa
# then mstatus mcounteren dcsr mcause mstatus_wdata mstatus_wmask and expected err_flags mode
boot0        1 3 00 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
boot1        1 3 01 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
idle0        0 0 00 00000000 0 00 0 0 0 00000000 00000000 0 0 00000000 00000000 00000000 00000 3
misa_s       1 3 02 00000013 0 00 0 0 0 40140100 00000000 0 3 00000000 00000000 00000000 80000 3
mpp2         1 3 03 00000013 0 00 0 0 0 40100100 00001000 0 3 00000000 00000000 00000000 10000 3
mcnt_nz      1 3 04 00000013 0 00 0 0 0 40100100 00000000 7 3 00000000 00000000 00000000 02000 3
fs_dirty     1 3 05 00000013 0 00 0 0 0 40100100 00002000 0 3 00000000 00000000 00000000 04000 3
mode2        1 2 06 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 40000 2
mret_m       1 3 07 30200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
to_user      1 0 08 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 0
wfi_tw0      1 0 09 10500073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 0
wfi_tw1      1 0 0a 10500073 0 00 0 0 0 40100100 00200000 0 3 00000000 00000000 00000000 00200 0
uret_u       1 0 0b 00200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00080 0
custom_u     1 0 0c 8c000073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00100 0
csr_m_u      1 0 0d 300020f3 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00020 0
csr_u_ok     1 0 0e c00020f3 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 0
wfi_trap     1 0 0f 10500073 6 02 0 0 0 40100100 00200000 0 3 00000000 00000000 00000000 00000 0
trap_bad     1 0 10 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00008 0
mret_u       1 0 11 30200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00040 0
mret_mpp     1 3 12 30200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00001800 00001800 00400 3
back_u       1 0 13 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 0
ill_u        1 0 14 00000000 6 02 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 0
trap_m       1 3 15 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
mret_ok      1 3 16 30200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
mret_bad     1 3 17 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00001 3
mret_int     1 3 18 30200073 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
intr_m       1 3 19 00000013 0 00 0 3 0 40100100 00000000 0 3 80000007 00000000 00000000 00000 3
dbg_enter    1 3 1a 00000013 0 00 0 0 1 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
dbg_in       1 3 1b 00000013 0 00 0 0 1 40100100 00000000 0 0 00000000 00000000 00000000 00000 3
dbg_exit_bad 1 3 1c 00000013 0 00 0 0 0 40100100 00000000 0 0 00000000 00000000 00000000 00002 3
dbg_u        1 0 1d 00000013 0 00 0 0 1 40100100 00000000 0 3 00000000 00000000 00000000 00004 0
dbg_exit_ok  1 3 1e 00000013 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00000 3
deleg_m      1 3 1f 302020f3 0 00 0 0 0 40100100 00000000 0 3 00000000 00000000 00000000 00010 3
idle1        0 0 00 00000000 0 00 0 0 0 00000000 00000000 0 0 00000000 00000000 00000000 00000 3

// File: project.f
+incdir+verilog
verilog/umode_pkg.sv
verilog/insn_classifier.sv
verilog/csr_field_checker.sv
verilog/privilege_rule_checker.sv
verilog/mode_transition_checker.sv
verilog/umode_monitor.sv
verification/tb_clock_gen.sv
verification/tb_umode_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Mdir obj_dir \
  --top-module tb_umode_monitor -f project.f

./obj_dir/Vtb_umode_monitor | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi
